//--- sim.f
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_controller.sv
verif/uart_controller_tb.sv

//--- Bender.yml
package:
  name: uart_controller

sources:
  - source/uart_pkg.sv
  - source/uart_fifo.sv
  - source/uart_rx.sv
  - source/uart_tx.sv
  - source/uart_controller.sv
  - target: simulation
    files:
      - verif/uart_controller_tb.sv

//--- verif/uart_controller_tb.sv
`timescale 1ns/10ps

module uart_controller_tb
    import uart_pkg::*;
();

    // one serial bit and one whole 8N1 frame in clocks
    localparam int BIT_CLKS   = OVERSAMPLE * BAUD_DIV;
    localparam int FRAME_CLKS = 10 * BIT_CLKS;

    logic              clk;
    logic              rst_n;
    logic              serial_in;
    logic              serial_out;
    logic              tx_valid;
    logic              tx_ready;
    logic [DATA_W-1:0] tx_data;
    logic              rx_valid;
    logic              rx_ready;
    logic [DATA_W-1:0] rx_data;
    logic              rx_overrun;
    logic              rx_frame_error;

    // scoreboard queues
    logic [DATA_W-1:0] exp_tx_q [$];
    logic [DATA_W-1:0] mon_q [$];
    logic [DATA_W-1:0] exp_rx_q [$];
    logic [DATA_W-1:0] got_rx_q [$];

    int          overrun_cnt;
    int          ferr_cnt;
    int          error_count;
    int          check_count;
    int          test_count;
    int          rx_mode;
    logic        saw_full;
    logic        mon_prev;
    logic [31:0] rng_state;
    logic [31:0] ready_state;

    always #5 clk = ~clk;

    uart_controller u_uart_controller (
        .clk            (clk),
        .rst_n          (rst_n),
        .serial_in      (serial_in),
        .serial_out     (serial_out),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .tx_data        (tx_data),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_data        (rx_data),
        .rx_overrun     (rx_overrun),
        .rx_frame_error (rx_frame_error)
    );

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // main stimulus stream
    function automatic logic [31:0] next_rand();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s had %0d errors", name, error_count - errors_before);
        end
    endtask

    // offer one byte and hold it until the fifo takes it
    // tx_ready only moves on a rising edge so the negedge value decides the transfer
    task automatic write_tx(input logic [DATA_W-1:0] b);
        int   cycles;
        logic done;
        cycles   = 0;
        done     = 1'b0;
        tx_valid = 1'b1;
        tx_data  = b;
        while (!done && cycles < 4 * FRAME_CLKS) begin
            if (tx_ready === 1'b1) begin
                exp_tx_q.push_back(b);
                done = 1'b1;
            end else begin
                saw_full = 1'b1;
            end
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            report_timeout("tx_ready");
        end
    endtask

    // one 8N1 frame on serial_in then idle high
    task automatic send_frame(input logic [DATA_W-1:0] b, input logic bad_stop,
                              input int idle_bits);
        int i;
        serial_in = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (i = 0; i < DATA_W; i++) begin
            serial_in = b[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        serial_in = !bad_stop;
        repeat (BIT_CLKS) @(negedge clk);
        serial_in = 1'b1;
        repeat (idle_bits * BIT_CLKS) @(negedge clk);
    endtask

    task automatic wait_tx_count(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (mon_q.size() < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (mon_q.size() < n) begin
            report_timeout("bytes on serial_out");
        end
    endtask

    task automatic wait_rx_count(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (got_rx_q.size() < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (got_rx_q.size() < n) begin
            report_timeout("bytes on rx_data");
        end
    endtask

    task automatic compare_tx(input string name);
        check_value({name, "_count"}, exp_tx_q.size(), mon_q.size());
        while (exp_tx_q.size() > 0 && mon_q.size() > 0) begin
            check_value(name, exp_tx_q.pop_front(), mon_q.pop_front());
        end
        exp_tx_q.delete();
        mon_q.delete();
    endtask

    task automatic compare_rx(input string name);
        check_value({name, "_count"}, exp_rx_q.size(), got_rx_q.size());
        while (exp_rx_q.size() > 0 && got_rx_q.size() > 0) begin
            check_value(name, exp_rx_q.pop_front(), got_rx_q.pop_front());
        end
        exp_rx_q.delete();
        got_rx_q.delete();
    endtask

    ////////////////////
    // line monitor
    ////////////////////

    // serial_out only changes on a rising edge so it is sampled at negedges
    always begin : tx_monitor
        logic [DATA_W-1:0] mon_byte;
        int                k;
        @(negedge clk);
        if (mon_prev === 1'b1 && serial_out === 1'b0) begin
            // middle of start bit
            repeat (BIT_CLKS / 2 - 1) @(negedge clk);
            check_value("tx_start_bit", 0, serial_out);
            for (k = 0; k < DATA_W; k++) begin
                repeat (BIT_CLKS) @(negedge clk);
                mon_byte[k] = serial_out;
            end
            repeat (BIT_CLKS) @(negedge clk);
            check_value("tx_stop_bit", 1, serial_out);
            mon_q.push_back(mon_byte);
        end
        mon_prev = serial_out;
    end

    ////////////////////
    // host rx side
    ////////////////////

    // ready decided here and the transfer lands on the next rising edge
    always @(negedge clk) begin : rx_host
        ready_state = lcg_step(ready_state);
        case (rx_mode)
            0:       rx_ready = 1'b0;
            1:       rx_ready = 1'b1;
            default: rx_ready = ready_state[17];
        endcase
        if (rx_valid === 1'b1 && rx_ready) begin
            got_rx_q.push_back(rx_data);
        end
        // status pulses are one cycle so each is seen once
        if (rx_overrun === 1'b1) begin
            overrun_cnt++;
        end
        if (rx_frame_error === 1'b1) begin
            ferr_cnt++;
        end
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin : main
        int                errs;
        int                i;
        int                base_ovr;
        int                base_fe;
        int                bad_cnt;
        int                good_cnt;
        int                cycles;
        logic              bad;
        logic [DATA_W-1:0] b;

        clk         = 1'b0;
        rst_n       = 1'b0;
        serial_in   = 1'b1;
        tx_valid    = 1'b0;
        tx_data     = '0;
        rx_ready    = 1'b0;
        rx_mode     = 1;
        mon_prev    = 1'b1;
        saw_full    = 1'b0;
        overrun_cnt = 0;
        ferr_cnt    = 0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        rng_state   = 32'h80cb_f2bc;
        // separate stream for the ready pattern
        ready_state = lcg_step(32'h80cb_f2bc);

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // reset state
        errs = error_count;
        check_value("reset_serial_out", 1, serial_out);
        check_value("reset_tx_ready", 1, tx_ready);
        check_value("reset_rx_valid", 0, rx_valid);
        check_value("reset_rx_overrun", 0, rx_overrun);
        check_value("reset_rx_frame_error", 0, rx_frame_error);
        finish_test("reset_state", errs);

        // transmit with random gaps
        errs = error_count;
        for (i = 0; i < 20; i++) begin
            write_tx(DATA_W'(next_rand() >> 8));
            tx_valid = 1'b0;
            repeat (next_rand() % 8) @(negedge clk);
        end
        wait_tx_count(20, 22 * FRAME_CLKS);
        repeat (BIT_CLKS) @(negedge clk);
        compare_tx("tx_order");
        finish_test("tx_order", errs);

        // receive with random host ready
        errs     = error_count;
        base_ovr = overrun_cnt;
        base_fe  = ferr_cnt;
        rx_mode  = 2;
        for (i = 0; i < 20; i++) begin
            b = DATA_W'(next_rand() >> 8);
            exp_rx_q.push_back(b);
            send_frame(b, 1'b0, 1 + next_rand() % 3);
        end
        wait_rx_count(20, 2 * FRAME_CLKS);
        check_value("rx_order_overrun", 0, overrun_cnt - base_ovr);
        check_value("rx_order_frame_error", 0, ferr_cnt - base_fe);
        compare_rx("rx_order");
        finish_test("rx_order", errs);

        // transmit back-pressure
        errs     = error_count;
        saw_full = 1'b0;
        for (i = 0; i < FIFO_DEPTH + 4; i++) begin
            write_tx(DATA_W'(next_rand() >> 8));
        end
        tx_valid = 1'b0;
        check_value("tx_backpressure_seen", 1, saw_full);
        wait_tx_count(FIFO_DEPTH + 4, (FIFO_DEPTH + 8) * FRAME_CLKS);
        repeat (BIT_CLKS) @(negedge clk);
        compare_tx("tx_backpressure");
        finish_test("tx_backpressure", errs);

        // receive overrun with host stalled
        errs     = error_count;
        base_ovr = overrun_cnt;
        base_fe  = ferr_cnt;
        rx_mode  = 0;
        for (i = 0; i < FIFO_DEPTH + 3; i++) begin
            b = DATA_W'(next_rand() >> 8);
            if (i < FIFO_DEPTH) begin
                exp_rx_q.push_back(b);
            end
            send_frame(b, 1'b0, 1);
        end
        cycles = 0;
        while (overrun_cnt - base_ovr < 3 && cycles < FRAME_CLKS) begin
            @(negedge clk);
            cycles++;
        end
        if (overrun_cnt - base_ovr < 3) begin
            report_timeout("rx_overrun pulses");
        end
        check_value("rx_overrun_pulses", 3, overrun_cnt - base_ovr);
        check_value("rx_overrun_frame_error", 0, ferr_cnt - base_fe);
        rx_mode = 1;
        wait_rx_count(FIFO_DEPTH, 4 * FIFO_DEPTH);
        repeat (4) @(negedge clk);
        compare_rx("rx_overrun");
        finish_test("rx_overrun", errs);

        // framing errors among good frames
        errs     = error_count;
        base_ovr = overrun_cnt;
        base_fe  = ferr_cnt;
        bad_cnt  = 0;
        good_cnt = 0;
        for (i = 0; i < 12; i++) begin
            b   = DATA_W'(next_rand() >> 8);
            bad = (next_rand() % 3 == 0) || (i == 5);
            if (bad) begin
                bad_cnt++;
            end else begin
                good_cnt++;
                exp_rx_q.push_back(b);
            end
            send_frame(b, bad, 2);
        end
        wait_rx_count(good_cnt, 2 * FRAME_CLKS);
        check_value("frame_error_pulses", bad_cnt, ferr_cnt - base_fe);
        check_value("frame_error_overrun", 0, overrun_cnt - base_ovr);
        compare_rx("frame_error");
        finish_test("frame_error", errs);

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- source/uart_controller.sv
`timescale 1ns/10ps

module uart_controller
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // serial line
    input  logic              serial_in,
    output logic              serial_out,

    // host transmit stream
    input  logic              tx_valid,
    output logic              tx_ready,
    input  logic [DATA_W-1:0] tx_data,

    // host receive stream
    output logic              rx_valid,
    input  logic              rx_ready,
    output logic [DATA_W-1:0] rx_data,

    // status pulses
    output logic              rx_overrun,
    output logic              rx_frame_error
);

    // oversampling tick
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic                  baud_tick;

    // tx fifo to serializer
    logic                  txf_valid;
    logic                  txf_ready;
    logic [DATA_W-1:0]     txf_data;

    // receiver to rx fifo
    logic                  rx_push;
    logic [DATA_W-1:0]     rx_byte;
    logic                  rxf_wr_ready;

    ////////////////////
    // baud divider
    ////////////////////

    // free running
    // one tick every BAUD_DIV clocks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            baud_cnt  <= '0;
            baud_tick <= 1'b0;
        end else if (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1)) begin
            baud_cnt  <= '0;
            baud_tick <= 1'b1;
        end else begin
            baud_cnt  <= baud_cnt + 1'b1;
            baud_tick <= 1'b0;
        end
    end

    ////////////////////
    // transmit path
    ////////////////////

    // host writes straight into the fifo
    uart_fifo u_tx_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (tx_valid),
        .wr_ready (tx_ready),
        .wr_data  (tx_data),
        .rd_valid (txf_valid),
        .rd_ready (txf_ready),
        .rd_data  (txf_data)
    );

    // pops only when idle
    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .baud_tick  (baud_tick),
        .byte_valid (txf_valid),
        .byte_ready (txf_ready),
        .byte_data  (txf_data),
        .serial_out (serial_out)
    );

    ////////////////////
    // receive path
    ////////////////////

    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .baud_tick   (baud_tick),
        .serial_in   (serial_in),
        .rx_push     (rx_push),
        .rx_byte     (rx_byte),
        .frame_error (rx_frame_error)
    );

    // receiver cannot stall
    // a push into a full fifo is dropped
    uart_fifo u_rx_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (rx_push),
        .wr_ready (rxf_wr_ready),
        .wr_data  (rx_byte),
        .rd_valid (rx_valid),
        .rd_ready (rx_ready),
        .rd_data  (rx_data)
    );

    // flag the dropped byte in the same cycle as the push
    assign rx_overrun = rx_push & ~rxf_wr_ready;

endmodule

//--- source/uart_tx.sv
`timescale 1ns/10ps

module uart_tx
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              baud_tick,
    // byte stream in
    input  logic              byte_valid,
    output logic              byte_ready,
    input  logic [DATA_W-1:0] byte_data,
    output logic              serial_out
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_SYNC,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t             state;
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [DATA_W-1:0]     shift_q;
    logic                  bit_done;

    // only take a byte when nothing is in flight
    assign byte_ready = (state == TX_IDLE);

    // last tick of the current bit
    assign bit_done = baud_tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= TX_IDLE;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            serial_out <= 1'b1;
        end else begin
            if (baud_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    if (byte_valid) begin
                        state <= TX_SYNC;
                    end
                end
                TX_SYNC: begin
                    // align start bit to a tick
                    if (baud_tick) begin
                        serial_out <= 1'b0;
                        tick_cnt   <= '0;
                        state      <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        serial_out <= shift_q[0];
                        bit_cnt    <= '0;
                        state      <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_CNT_W'(DATA_W - 1)) begin
                            serial_out <= 1'b1;
                            state      <= TX_STOP;
                        end else begin
                            serial_out <= shift_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    // ready again after last stop tick
                    if (bit_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // load on accept
    // shift right as each bit goes out
    always_ff @(posedge clk) begin
        if (byte_valid && byte_ready) begin
            shift_q <= byte_data;
        end else if (bit_done && ((state == TX_START) || (state == TX_DATA))) begin
            shift_q <= {1'b0, shift_q[DATA_W-1:1]};
        end
    end

endmodule

//--- source/uart_rx.sv
`timescale 1ns/10ps

module uart_rx
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              baud_tick,
    input  logic              serial_in,
    // push-only byte stream
    output logic              rx_push,
    output logic [DATA_W-1:0] rx_byte,
    output logic              frame_error
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t             state;
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [DATA_W-1:0]     shift_q;

    // synchronizer and edge detect
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic start_edge;

    // tick strobes
    logic half_bit;
    logic mid_bit;

    ////////////////////
    // line input
    ////////////////////

    // idle line is high so the flops come out of reset high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= serial_in;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // a start needs a real high to low transition
    // so a held-low line after a bad stop bit does not retrigger
    assign start_edge = rx_prev & ~rx_sync;

    // middle of start bit after 8 ticks
    assign half_bit = baud_tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE/2 - 1));
    // middle of a data or stop bit after 16 more
    assign mid_bit  = baud_tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));

    ////////////////////
    // frame fsm
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= RX_IDLE;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            rx_push     <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            // pulses last one cycle
            rx_push     <= 1'b0;
            frame_error <= 1'b0;
            if (baud_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    if (start_edge) begin
                        tick_cnt <= '0;
                        state    <= RX_START;
                    end
                end
                RX_START: begin
                    // glitch check at mid start bit
                    if (half_bit) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_CNT_W'(DATA_W - 1)) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    // stop bit decides push or error
                    if (mid_bit) begin
                        rx_push     <= rx_sync;
                        frame_error <= ~rx_sync;
                        state       <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first so shift in from the top
    always_ff @(posedge clk) begin
        if ((state == RX_DATA) && mid_bit) begin
            shift_q <= {rx_sync, shift_q[DATA_W-1:1]};
        end
    end

    // held stable until the next frame's data bits
    assign rx_byte = shift_q;

endmodule

//--- source/uart_fifo.sv
`timescale 1ns/10ps

module uart_fifo
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // write side
    input  logic              wr_valid,
    output logic              wr_ready,
    input  logic [DATA_W-1:0] wr_data,
    // read side
    output logic              rd_valid,
    input  logic              rd_ready,
    output logic [DATA_W-1:0] rd_data
);

    // storage and pointers
    logic [DATA_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;

    // transfer strobes
    logic do_wr;
    logic do_rd;

    // full when every entry is held
    assign wr_ready = (count != (FIFO_PTR_W+1)'(FIFO_DEPTH));
    // any entry held
    assign rd_valid = (count != '0);

    assign do_wr = wr_valid & wr_ready;
    assign do_rd = rd_valid & rd_ready;

    // oldest entry always on the read port
    assign rd_data = mem[rd_ptr];

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // count only moves when one side transfers alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // data array
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- source/uart_pkg.sv
package uart_pkg;

    // character format
    // 8 data bits, no parity, one stop bit
    localparam int DATA_W     = 8;

    // ticks per bit period
    localparam int OVERSAMPLE = 16;

    // clocks per oversampling tick
    // kept small so one bit lasts 64 clocks in simulation
    localparam int BAUD_DIV   = 4;
    localparam int BAUD_CNT_W = 2;

    // byte fifo geometry
    // occupancy count is one bit wider than the pointers
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = 4;

    // counters inside the serial engines
    localparam int TICK_CNT_W = 4;
    localparam int BIT_CNT_W  = 3;

endpackage
